// ==== Makefile ====
TOP := tb_ats_query

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_ats_query.sv ====
// Directed tests only; expects a 100 ns clock, PASID and base written before any request command
`timescale 1ns/1ps

`include "ats_query_macros.svh"

module tb_ats_query
    import ats_query_pkg::*;
;

    // About twenty times the length of all directed tests
    localparam int MAX_CYCLES = 3000;

    logic       clk;
    logic       rst_n;
    logic       mmio_req;
    logic       mmio_we;
    csr_addr_t  mmio_addr;
    csr_data_t  mmio_wdata;
    logic       mmio_ack;
    csr_data_t  mmio_rdata;
    logic       rd_req;
    host_addr_t rd_addr;
    dw_len_t    rd_len;
    tag_t       rd_tag;
    pasid_t     rd_pasid;
    logic       rd_ats;
    logic       rd_ack;
    logic       page_req;
    host_addr_t page_addr;
    pasid_t     page_pasid;
    logic       page_ack;
    logic       page_rsp;
    logic       cpl_valid;
    logic       cpl_last;
    csr_data_t  cpl_data;

    integer     seed = 24;
    int         cycle_count = 0;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    pasid_t     pasid_w;
    host_addr_t base_w;

    ats_query_top dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ============================================================
    // Checking and reporting
    // ============================================================

    task automatic check_eq(input string name, input csr_data_t got, input csr_data_t exp);
        assert (got === exp)
        else
        begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("Test %-14s PASS", name);
        else
        begin
            tests_failed++;
            $display("Test %-14s FAIL (%0d errors)", name, errors - errs_before);
        end
    endtask

    // ============================================================
    // Host and environment models
    // ============================================================

    task automatic mmio_access(input logic we, input csr_addr_t addr, input csr_data_t wdata,
                               output csr_data_t rdata);
        @(posedge clk);
        mmio_req   <= 1'b1;
        mmio_we    <= we;
        mmio_addr  <= addr;
        mmio_wdata <= wdata;
        @(negedge clk);
        while (!mmio_ack)
            @(negedge clk);
        rdata = mmio_rdata;
        @(posedge clk);
        mmio_req <= 1'b0;
        @(negedge clk);
        while (mmio_ack)
            @(negedge clk);
    endtask

    task automatic mmio_write(input csr_addr_t addr, input csr_data_t wdata);
        csr_data_t unused_rdata;
        mmio_access(1'b1, addr, wdata, unused_rdata);
    endtask

    task automatic mmio_read(input csr_addr_t addr, output csr_data_t rdata);
        mmio_access(1'b0, addr, '0, rdata);
    endtask

    task automatic ack_rd(input host_addr_t addr, input dw_len_t len, input tag_t tag,
                          input pasid_t pasid, input logic ats);
        integer lat;
        @(negedge clk);
        while (!rd_req)
            @(negedge clk);
        check_eq("rd_addr", rd_addr, addr);
        check_eq("rd_len", csr_data_t'(rd_len), csr_data_t'(len));
        check_eq("rd_tag", csr_data_t'(rd_tag), csr_data_t'(tag));
        check_eq("rd_pasid", csr_data_t'(rd_pasid), csr_data_t'(pasid));
        check_eq("rd_ats", csr_data_t'(rd_ats), csr_data_t'(ats));
        // Random ack latency
        lat = ($random(seed) & 3) + 1;
        repeat (lat) @(posedge clk);
        rd_ack <= 1'b1;
        @(negedge clk);
        while (rd_req)
            @(negedge clk);
        @(posedge clk);
        rd_ack <= 1'b0;
    endtask

    task automatic ack_page(input host_addr_t addr, input pasid_t pasid);
        @(negedge clk);
        while (!page_req)
            @(negedge clk);
        check_eq("page_addr", page_addr, addr);
        check_eq("page_pasid", csr_data_t'(page_pasid), csr_data_t'(pasid));
        @(posedge clk);
        page_ack <= 1'b1;
        @(negedge clk);
        while (page_req)
            @(negedge clk);
        @(posedge clk);
        page_ack <= 1'b0;
    endtask

    task automatic send_cpl(input csr_data_t first, input csr_data_t second);
        @(posedge clk);
        cpl_valid <= 1'b1;
        cpl_last  <= 1'b0;
        cpl_data  <= first;
        @(posedge clk);
        cpl_last  <= 1'b1;
        cpl_data  <= second;
        @(posedge clk);
        cpl_valid <= 1'b0;
        cpl_last  <= 1'b0;
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic read_identity();
        int        e0;
        csr_data_t v;
        logic [127:0] afu;
        e0  = errors;
        afu = `AFU_ID;
        mmio_read(4'd0, v);
        check_eq("dfh[63:60]", csr_data_t'(v[63:60]), 64'h1);
        check_eq("dfh[40]", csr_data_t'(v[40]), 64'h1);
        mmio_read(4'd1, v);
        check_eq("afu_id_l", v, afu[63:0]);
        mmio_read(4'd2, v);
        check_eq("afu_id_h", v, afu[127:64]);
        mmio_read(4'd5, v);
        check_eq("csr[5]", v, 64'h0);
        report_test("identity", e0);
    endtask

    task automatic plain_read();
        int        e0;
        csr_data_t v;
        e0      = errors;
        pasid_w = pasid_t'($random(seed));
        base_w  = {$random(seed), $random(seed)};
        mmio_write(4'd0, csr_data_t'(pasid_w));
        mmio_write(4'd1, base_w);
        mmio_write(4'd2, 64'd5);
        mmio_write(4'd7, 64'd2);
        ack_rd(base_w & ~64'hfff, 10'd5, 8'd0, pasid_w, 1'b0);
        mmio_read(4'd8, v);
        check_eq("rd_sent", v, 64'd1);
        report_test("plain_read", e0);
    endtask

    task automatic ats_query();
        int        e0;
        csr_data_t v;
        csr_data_t beat0;
        e0    = errors;
        beat0 = {$random(seed), $random(seed)};
        mmio_write(4'd7, 64'd1);
        ack_rd(base_w & ~64'hfff, 10'd5, 8'd1, pasid_w, 1'b1);
        send_cpl(beat0, ~beat0);
        mmio_read(4'd10, v);
        check_eq("last_cpl", v, beat0);
        mmio_read(4'd9, v);
        check_eq("cpl_rcvd", v, 64'd1);
        report_test("ats_query", e0);
    endtask

    task automatic page_request();
        int        e0;
        csr_data_t v0;
        csr_data_t v1;
        csr_data_t v2;
        e0 = errors;
        mmio_write(4'd7, 64'd4);
        ack_page(base_w & ~64'hfff, pasid_w);
        @(posedge clk);
        page_rsp <= 1'b1;
        @(posedge clk);
        page_rsp <= 1'b0;
        mmio_read(4'd12, v0);
        assert (v0 != 64'h0)
        else
        begin
            $display("Active cycle count stayed at zero during the page request");
            errors++;
        end
        // Counting must stop once the response is in
        mmio_read(4'd12, v1);
        mmio_read(4'd12, v2);
        check_eq("test_cycles", v1, v0);
        check_eq("test_cycles", v2, v0);
        report_test("page_request", e0);
    endtask

    task automatic clear_counters();
        int        e0;
        csr_data_t v;
        csr_data_t beat0;
        e0    = errors;
        beat0 = {$random(seed), $random(seed)};
        // Load every counter before the clear
        mmio_write(4'd7, 64'd2);
        ack_rd(base_w & ~64'hfff, 10'd5, 8'd2, pasid_w, 1'b0);
        send_cpl(beat0, ~beat0);
        mmio_write(4'd7, 64'd0);
        mmio_read(4'd8, v);
        check_eq("rd_sent", v, 64'h0);
        mmio_read(4'd9, v);
        check_eq("cpl_rcvd", v, 64'h0);
        mmio_read(4'd12, v);
        check_eq("test_cycles", v, 64'h0);
        mmio_read(4'd10, v);
        check_eq("last_cpl", v, 64'hdeadbeef);
        report_test("clear", e0);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        mmio_req   = 1'b0;
        mmio_we    = 1'b0;
        mmio_addr  = '0;
        mmio_wdata = '0;
        rd_ack     = 1'b0;
        page_ack   = 1'b0;
        page_rsp   = 1'b0;
        cpl_valid  = 1'b0;
        cpl_last   = 1'b0;
        cpl_data   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        read_identity();
        plain_read();
        ats_query();
        page_request();
        clear_counters();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hdl/ats_query_pkg.sv ====
// Field widths and command bit positions shared by the engine; all types are unsigned
package ats_query_pkg;

    // ============================================================
    // Field types
    // ============================================================

    // Index of a 64-bit CSR word
    typedef logic [3:0]  csr_addr_t;
    // One CSR word, also the first 64 bits of a completion
    typedef logic [63:0] csr_data_t;
    // Host byte address
    typedef logic [63:0] host_addr_t;
    // Read length in DWORDs
    typedef logic [9:0]  dw_len_t;
    typedef logic [7:0]  tag_t;
    typedef logic [19:0] pasid_t;
    // Statistics counters
    typedef logic [39:0] count_t;

    // ============================================================
    // Command register bits
    // ============================================================

    typedef enum logic [5:0] {
        cmd_ats  = 6'd0,
        cmd_rd   = 6'd1,
        cmd_page = 6'd2
    } cmd_bit_e;

endpackage

// ==== hdl/ats_query_top.sv ====
// Bandwidth and ATS test engine; requests and completions use plain field ports, no TLP packing
`timescale 1ns/1ps

module ats_query_top
    import ats_query_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mmio_req,
    input  logic       mmio_we,
    input  csr_addr_t  mmio_addr,
    input  csr_data_t  mmio_wdata,
    output logic       mmio_ack,
    output csr_data_t  mmio_rdata,
    output logic       rd_req,
    output host_addr_t rd_addr,
    output dw_len_t    rd_len,
    output tag_t       rd_tag,
    output pasid_t     rd_pasid,
    output logic       rd_ats,
    input  logic       rd_ack,
    output logic       page_req,
    output host_addr_t page_addr,
    output pasid_t     page_pasid,
    input  logic       page_ack,
    input  logic       page_rsp,
    input  logic       cpl_valid,
    input  logic       cpl_last,
    input  csr_data_t  cpl_data
);

    pasid_t     cfg_pasid;
    host_addr_t cfg_base;
    dw_len_t    cfg_len;
    logic       start_rd;
    logic       start_ats;
    logic       start_page;
    logic       counter_clear;
    logic       rd_active;
    logic       page_active;
    count_t     rd_sent;
    count_t     cpl_rcvd;
    count_t     test_cycles;
    csr_data_t  last_cpl;

    csr_regs u_csr_regs (
        .clk, .rst_n,
        .mmio_req, .mmio_we, .mmio_addr, .mmio_wdata, .mmio_ack, .mmio_rdata,
        .rd_sent, .cpl_rcvd, .test_cycles, .last_cpl,
        .cfg_pasid, .cfg_base, .cfg_len,
        .start_rd, .start_ats, .start_page, .counter_clear
    );

    rd_req_gen u_rd_req_gen (
        .clk, .rst_n,
        .start_rd, .start_ats, .cfg_pasid, .cfg_base, .cfg_len, .counter_clear,
        .rd_ack, .cpl_valid,
        .rd_req, .rd_addr, .rd_len, .rd_tag, .rd_pasid, .rd_ats,
        .rd_active, .rd_sent
    );

    page_req_gen u_page_req_gen (
        .clk, .rst_n,
        .start_page, .cfg_pasid, .cfg_base, .page_ack, .page_rsp,
        .page_req, .page_addr, .page_pasid, .page_active
    );

    cpl_monitor u_cpl_monitor (
        .clk, .rst_n,
        .cpl_valid, .cpl_last, .cpl_data, .rd_active, .page_active, .counter_clear,
        .cpl_rcvd, .last_cpl, .test_cycles
    );

endmodule

// ==== hdl/cpl_monitor.sv ====
// Completions are never back-pressured; every valid beat is taken as received
`timescale 1ns/1ps

`include "ats_query_macros.svh"

module cpl_monitor
    import ats_query_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpl_valid,
    input  logic      cpl_last,
    input  csr_data_t cpl_data,
    input  logic      rd_active,
    input  logic      page_active,
    input  logic      counter_clear,
    output count_t    cpl_rcvd,
    output csr_data_t last_cpl,
    output count_t    test_cycles
);

    // High when the next beat opens a completion
    logic cpl_sop;
    logic clear;

    assign clear = !rst_n || counter_clear;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cpl_sop <= 1'b1;
        else if (cpl_valid)
            cpl_sop <= cpl_last;
    end

    // ============================================================
    // Completion statistics
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            cpl_rcvd <= '0;
            last_cpl <= `LAST_CPL_RESET;
        end
        else
        begin
            // Enough to hold a translation response
            if (cpl_valid && cpl_sop)
                last_cpl <= cpl_data;
            if (cpl_valid && cpl_last)
                cpl_rcvd <= cpl_rcvd + count_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (clear)
            test_cycles <= '0;
        else if (rd_active || page_active)
            test_cycles <= test_cycles + count_t'(1);
    end

endmodule

// ==== hdl/csr_regs.sv ====
// Serves one MMIO access at a time; reads are captured when ack rises and held until release
`timescale 1ns/1ps

`include "ats_query_macros.svh"

module csr_regs
    import ats_query_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mmio_req,
    input  logic       mmio_we,
    input  csr_addr_t  mmio_addr,
    input  csr_data_t  mmio_wdata,
    output logic       mmio_ack,
    output csr_data_t  mmio_rdata,
    input  count_t     rd_sent,
    input  count_t     cpl_rcvd,
    input  count_t     test_cycles,
    input  csr_data_t  last_cpl,
    output pasid_t     cfg_pasid,
    output host_addr_t cfg_base,
    output dw_len_t    cfg_len,
    output logic       start_rd,
    output logic       start_ats,
    output logic       start_page,
    output logic       counter_clear
);

    typedef enum logic [1:0] {
        s_idle,
        s_ack,
        s_release
    } mmio_state_e;

    mmio_state_e state;
    logic        accept;
    csr_data_t   rd_mux;
    logic [127:0] afu_id;

    assign afu_id   = `AFU_ID;
    assign accept   = (state == s_idle) && mmio_req;
    assign mmio_ack = (state == s_ack);

    // ============================================================
    // Four-phase responder
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= s_idle;
        end
        else
        begin
            case (state)
                s_idle:
                begin
                    if (mmio_req)
                        state <= s_ack;
                end
                s_ack:
                begin
                    if (!mmio_req)
                        state <= s_release;
                end
                default:
                    state <= s_idle;
            endcase
        end
    end

    // ============================================================
    // Write registers and command decode
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg_len       <= `RD_LEN_RESET;
            start_rd      <= 1'b0;
            start_ats     <= 1'b0;
            start_page    <= 1'b0;
            counter_clear <= 1'b0;
        end
        else
        begin
            // Starts and clear are single-cycle pulses
            start_rd      <= 1'b0;
            start_ats     <= 1'b0;
            start_page    <= 1'b0;
            counter_clear <= 1'b0;

            if (accept && mmio_we)
            begin
                case (mmio_addr)
                    `CSR_LEN:
                        cfg_len <= mmio_wdata[$bits(dw_len_t)-1:0];
                    `CSR_CMD:
                    begin
                        counter_clear <= 1'b1;
                        start_rd      <= mmio_wdata[cmd_ats] | mmio_wdata[cmd_rd];
                        start_ats     <= mmio_wdata[cmd_ats];
                        start_page    <= mmio_wdata[cmd_page];
                    end
                    default:
                        ;
                endcase
            end
        end
    end

    // Request configuration written by the host
    always_ff @(posedge clk)
    begin
        if (accept && mmio_we && (mmio_addr == `CSR_PASID))
            cfg_pasid <= mmio_wdata[$bits(pasid_t)-1:0];
        if (accept && mmio_we && (mmio_addr == `CSR_BASE))
            cfg_base <= mmio_wdata;
    end

    // ============================================================
    // Read mux
    // ============================================================

    always_comb
    begin
        rd_mux = '0;
        case (mmio_addr)
            `CSR_DFH:
            begin
                // Feature type AFU
                rd_mux[63:60] = 4'h1;
                // End of feature list
                rd_mux[40]    = 1'b1;
            end
            `CSR_AFU_ID_L: rd_mux = afu_id[63:0];
            `CSR_AFU_ID_H: rd_mux = afu_id[127:64];
            `CSR_RD_SENT:  rd_mux = csr_data_t'(rd_sent);
            `CSR_CPL_RCVD: rd_mux = csr_data_t'(cpl_rcvd);
            `CSR_LAST_CPL: rd_mux = last_cpl;
            `CSR_CYCLES:   rd_mux = csr_data_t'(test_cycles);
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            mmio_rdata <= rd_mux;
    end

    // The host holds req until ack rises
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mmio_ack) |-> mmio_req);

endmodule

// ==== hdl/page_req_gen.sv ====
// A new page request waits until the previous page response has arrived
`timescale 1ns/1ps

`include "ats_query_macros.svh"

module page_req_gen
    import ats_query_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_page,
    input  pasid_t     cfg_pasid,
    input  host_addr_t cfg_base,
    input  logic       page_ack,
    input  logic       page_rsp,
    output logic       page_req,
    output host_addr_t page_addr,
    output pasid_t     page_pasid,
    output logic       page_active
);

    typedef enum logic [1:0] {
        p_idle,
        p_req,
        p_drop
    } page_state_e;

    page_state_e state;
    logic        pend;
    logic        launch;

    assign launch   = (state == p_idle) && !page_active && (start_page || pend);
    assign page_req = (state == p_req);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= p_idle;
            pend        <= 1'b0;
            page_active <= 1'b0;
        end
        else
        begin
            if (launch)
                pend <= 1'b0;
            else if (start_page)
                pend <= 1'b1;

            case (state)
                p_idle:  if (launch) state <= p_req;
                p_req:   if (page_ack) state <= p_drop;
                default: if (!page_ack) state <= p_idle;
            endcase

            // Outstanding until the response message
            if (launch)
                page_active <= 1'b1;
            else if (page_rsp)
                page_active <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            page_addr  <= {cfg_base[63:`PAGE_MASK_BITS], {`PAGE_MASK_BITS{1'b0}}};
            page_pasid <= cfg_pasid;
        end
    end

    // The responder only acks a live message request
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(page_ack) |-> page_req);

endmodule

// ==== hdl/rd_req_gen.sv ====
// One read in flight at a time; a start that arrives while busy is merged into one pending start
`timescale 1ns/1ps

`include "ats_query_macros.svh"

module rd_req_gen
    import ats_query_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_rd,
    input  logic       start_ats,
    input  pasid_t     cfg_pasid,
    input  host_addr_t cfg_base,
    input  dw_len_t    cfg_len,
    input  logic       counter_clear,
    input  logic       rd_ack,
    input  logic       cpl_valid,
    output logic       rd_req,
    output host_addr_t rd_addr,
    output dw_len_t    rd_len,
    output tag_t       rd_tag,
    output pasid_t     rd_pasid,
    output logic       rd_ats,
    output logic       rd_active,
    output count_t     rd_sent
);

    typedef enum logic [1:0] {
        r_idle,
        r_req,
        r_drop
    } rd_state_e;

    rd_state_e state;
    logic      pend;
    logic      pend_ats;
    logic      launch;

    assign launch = (state == r_idle) && (start_rd || pend);
    assign rd_req = (state == r_req);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= r_idle;
            pend      <= 1'b0;
            pend_ats  <= 1'b0;
            rd_tag    <= '0;
            rd_active <= 1'b0;
        end
        else
        begin
            if (launch)
                pend <= 1'b0;
            else if (start_rd)
            begin
                pend     <= 1'b1;
                pend_ats <= start_ats;
            end

            case (state)
                r_idle:
                begin
                    if (launch)
                        state <= r_req;
                end
                r_req:
                begin
                    if (rd_ack)
                    begin
                        state  <= r_drop;
                        rd_tag <= rd_tag + tag_t'(1);
                    end
                end
                default:
                begin
                    // Wait for the ack to fall before the next request
                    if (!rd_ack)
                        state <= r_idle;
                end
            endcase

            // Cleared by the next completion beat
            if (launch)
                rd_active <= 1'b1;
            else if (cpl_valid)
                rd_active <= 1'b0;
        end
    end

    // Request fields, frozen for the whole handshake
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            rd_addr  <= {cfg_base[63:`PAGE_MASK_BITS], {`PAGE_MASK_BITS{1'b0}}};
            rd_len   <= cfg_len;
            rd_pasid <= cfg_pasid;
            rd_ats   <= start_rd ? start_ats : pend_ats;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || counter_clear)
            rd_sent <= '0;
        else if (rd_req && rd_ack)
            rd_sent <= rd_sent + count_t'(1);
    end

    // The responder only acks a live request
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_ack) |-> rd_req);

endmodule

// ==== include/ats_query_macros.svh ====
// CSR map and constants; read and write indices overlap and are decoded separately
`ifndef ATS_QUERY_MACROS_SVH
`define ATS_QUERY_MACROS_SVH

// Read side CSR indices
`define CSR_DFH         4'd0
`define CSR_AFU_ID_L    4'd1
`define CSR_AFU_ID_H    4'd2
`define CSR_RD_SENT     4'd8
`define CSR_CPL_RCVD    4'd9
`define CSR_LAST_CPL    4'd10
`define CSR_CYCLES      4'd12

// Write side CSR indices
`define CSR_PASID       4'd0
`define CSR_BASE        4'd1
`define CSR_LEN         4'd2
`define CSR_CMD         4'd7

// Reset and clear values
`define RD_LEN_RESET    10'd2
`define LAST_CPL_RESET  64'hdeadbeef

`define AFU_ID          128'h3f0a_91c4_6b2e_4d87_a5c1_0e9b_7d24_f6e3

// Low address bits cleared in every request
`define PAGE_MASK_BITS  12

`endif

// ==== verilog.f ====
+incdir+include
hdl/ats_query_pkg.sv
hdl/csr_regs.sv
hdl/rd_req_gen.sv
hdl/page_req_gen.sv
hdl/cpl_monitor.sv
hdl/ats_query_top.sv
dv/tb_ats_query.sv
